/* hdl/maze_pkg.sv */
`default_nettype none

package maze_pkg;

    // ------------------------------------------------------------------------
    // Screen geometry
    // ------------------------------------------------------------------------
    localparam int CoordWidth = 11;
    typedef logic [CoordWidth-1:0] coord_t;

    localparam int ChanWidth = 8;
    typedef logic [3*ChanWidth-1:0] colour_t;   // R in top byte then G then B

    localparam int SpriteHalf = 4;              // 8x8 solid sprites

    // ------------------------------------------------------------------------
    // Pellets and scoring
    // ------------------------------------------------------------------------
    localparam int PelletCount = 10;
    localparam coord_t PelletX [PelletCount] = '{
        11'd11, 11'd27, 11'd67, 11'd131, 11'd179,
        11'd275, 11'd339, 11'd419, 11'd555, 11'd627
    };
    localparam coord_t PelletY [PelletCount] = '{
        11'd467, 11'd219, 11'd107, 11'd227, 11'd11,
        11'd467, 11'd211, 11'd11, 11'd451, 11'd163
    };
    localparam coord_t PowerX = 11'd99;
    localparam coord_t PowerY = 11'd107;

    localparam int PelletDrawR2 = 4;
    localparam int PowerDrawR2  = 9;
    localparam int EatR2        = 16;           // Player centre pickup radius squared
    localparam int PowerScore   = 3;
    localparam int ScoreWidth   = 4;

    localparam int FrightFrames     = 48;
    localparam int FrightCountWidth = $clog2(FrightFrames + 1);

    // ------------------------------------------------------------------------
    // Maze walls with bounds exclusive on both sides
    // ------------------------------------------------------------------------
    localparam coord_t BorderWidth = 11'd8;
    localparam coord_t BorderMaxX  = 11'd631;
    localparam coord_t BorderMaxY  = 11'd471;

    typedef struct packed {
        coord_t xLo;
        coord_t xHi;
        coord_t yLo;
        coord_t yHi;
    } rect_t;

    localparam int WallCount = 12;
    localparam rect_t WallRects [WallCount] = '{
        '{11'd15, 11'd40, 11'd15,  11'd112},
        '{11'd15, 11'd40, 11'd119, 11'd152},
        '{11'd15, 11'd24, 11'd151, 11'd224},
        '{11'd31, 11'd40, 11'd159, 11'd224},
        '{11'd15, 11'd40, 11'd223, 11'd232},
        '{11'd15, 11'd40, 11'd239, 11'd256},
        '{11'd15, 11'd24, 11'd255, 11'd392},
        '{11'd31, 11'd40, 11'd263, 11'd384},
        '{11'd15, 11'd40, 11'd391, 11'd400},
        '{11'd15, 11'd40, 11'd407, 11'd472},
        '{11'd47, 11'd96, 11'd15,  11'd104},
        '{11'd47, 11'd96, 11'd111, 11'd216}
    };

    // ------------------------------------------------------------------------
    // Palette
    // ------------------------------------------------------------------------
    localparam colour_t PlayerColour     = 24'hFFFF00;
    localparam colour_t WallColour       = 24'h0042FF;
    localparam colour_t GhostRedColour   = 24'hFF0000;
    localparam colour_t GhostGreenColour = 24'h00FF00;
    localparam colour_t GhostPinkColour  = 24'hFF26FF;
    localparam colour_t FrightColour     = 24'h0000FF;
    localparam colour_t PelletColour     = 24'hFF0001;
    localparam colour_t PowerColour      = 24'h50B948;
    localparam colour_t Background       = 24'h000000;

    // Sprite box test in int so that centres near 0 do not wrap
    function automatic logic inBox(coord_t px, coord_t py, coord_t cx, coord_t cy);
        return (int'(px) > int'(cx) - SpriteHalf) && (int'(px) <= int'(cx) + SpriteHalf)
            && (int'(py) > int'(cy) - SpriteHalf) && (int'(py) <= int'(cy) + SpriteHalf);
    endfunction

    function automatic int dist2(coord_t ax, coord_t ay, coord_t bx, coord_t by);
        int dx;
        int dy;
        dx = int'(ax) - int'(bx);
        dy = int'(ay) - int'(by);
        return dx * dx + dy * dy;
    endfunction

endpackage

`default_nettype wire

/* hdl/maze_walls.sv */
`timescale 1ns/100ps
`default_nettype none

module maze_walls (
    input  maze_pkg::coord_t drawX,
    input  maze_pkg::coord_t drawY,
    output logic             wallPixel
);
    import maze_pkg::*;

    logic onBorder;
    logic [WallCount-1:0] inRect;

    // Outer frame of the playfield
    assign onBorder = (drawY < BorderWidth) || (drawX < BorderWidth)
                   || (drawY > BorderMaxY) || (drawX > BorderMaxX);

    // ------------------------------------------------------------------------
    // Interior blocks with one comparator set per table entry
    // ------------------------------------------------------------------------
    always_comb begin
        for (int i = 0; i < WallCount; i++) begin
            inRect[i] = (drawX > WallRects[i].xLo) && (drawX < WallRects[i].xHi)
                     && (drawY > WallRects[i].yLo) && (drawY < WallRects[i].yHi);
        end
    end

    assign wallPixel = onBorder || (|inRect);

endmodule

`default_nettype wire

/* hdl/pellet_tracker.sv */
`timescale 1ns/100ps
`default_nettype none

module pellet_tracker (
    input  logic                                frame_clk,
    input  logic                                over,
    input  maze_pkg::coord_t                    ballX,
    input  maze_pkg::coord_t                    ballY,
    input  maze_pkg::coord_t                    drawX,
    input  maze_pkg::coord_t                    drawY,
    output logic                                pelletPixel,
    output logic                                powerPixel,
    output logic [maze_pkg::ScoreWidth-1:0]     score,
    output logic                                powerEaten
);
    import maze_pkg::*;

    logic [PelletCount-1:0] eaten;
    logic [PelletCount-1:0] nearPellet;     // Player centre within pickup radius
    logic [PelletCount-1:0] drawPellet;     // Pixel inside a pellet disc
    logic                   nearPower;

    // ------------------------------------------------------------------------
    // Pickup detection against the player centre
    // ------------------------------------------------------------------------
    always_comb begin
        for (int i = 0; i < PelletCount; i++) begin
            nearPellet[i] = dist2(ballX, ballY, PelletX[i], PelletY[i]) <= EatR2;
        end
    end

    assign nearPower = dist2(ballX, ballY, PowerX, PowerY) <= EatR2;

    // Eaten flags are sticky until the next game over
    always_ff @(posedge frame_clk or posedge over) begin
        if (over) begin
            eaten      <= '0;
            powerEaten <= 1'b0;
        end else begin
            eaten <= eaten | nearPellet;
            if (nearPower) begin
                powerEaten <= 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Score
    // ------------------------------------------------------------------------
    always_comb begin
        score = '0;
        for (int i = 0; i < PelletCount; i++) begin
            score = score + ScoreWidth'(eaten[i]);
        end
        if (powerEaten) begin
            score = score + ScoreWidth'(PowerScore);
        end
    end

    // ------------------------------------------------------------------------
    // Pixel flags for live pellets only
    // ------------------------------------------------------------------------
    always_comb begin
        for (int i = 0; i < PelletCount; i++) begin
            drawPellet[i] = (dist2(drawX, drawY, PelletX[i], PelletY[i]) <= PelletDrawR2)
                         && !eaten[i];
        end
    end

    assign pelletPixel = |drawPellet;
    assign powerPixel  = !powerEaten
                      && (dist2(drawX, drawY, PowerX, PowerY) <= PowerDrawR2);

endmodule

`default_nettype wire

/* hdl/frightened_timer.sv */
`timescale 1ns/100ps
`default_nettype none

module frightened_timer (
    input  logic frame_clk,
    input  logic over,
    input  logic powerEaten,
    output logic frightened
);
    import maze_pkg::*;

    logic [FrightCountWidth-1:0] count;
    logic                        powerSeen;     // powerEaten one frame late
    logic                        start;

    // Only the rising event arms the timer
    assign start = powerEaten && !powerSeen && (count == '0);

    always_ff @(posedge frame_clk or posedge over) begin
        if (over) begin
            powerSeen <= 1'b0;
            count     <= '0;
        end else begin
            powerSeen <= powerEaten;
            if (start) begin
                count <= FrightCountWidth'(FrightFrames);
            end else if (count != '0) begin
                count <= count - 1'b1;          // Counts down once per frame
            end
        end
    end

    // High for FrightFrames frames from load down to 1
    assign frightened = (count != '0);

endmodule

`default_nettype wire

/* hdl/pixel_colour.sv */
`timescale 1ns/100ps
`default_nettype none

module pixel_colour (
    input  maze_pkg::coord_t                drawX,
    input  maze_pkg::coord_t                drawY,
    input  maze_pkg::coord_t                ballX,
    input  maze_pkg::coord_t                ballY,
    input  maze_pkg::coord_t                ghostRedX,
    input  maze_pkg::coord_t                ghostRedY,
    input  maze_pkg::coord_t                ghostGreenX,
    input  maze_pkg::coord_t                ghostGreenY,
    input  maze_pkg::coord_t                ghostPinkX,
    input  maze_pkg::coord_t                ghostPinkY,
    input  logic                            wallPixel,
    input  logic                            pelletPixel,
    input  logic                            powerPixel,
    input  logic                            frightened,
    output logic [maze_pkg::ChanWidth-1:0]  vgaR,
    output logic [maze_pkg::ChanWidth-1:0]  vgaG,
    output logic [maze_pkg::ChanWidth-1:0]  vgaB
);
    import maze_pkg::*;

    logic    playerOn;
    logic    redOn;
    logic    greenOn;
    logic    pinkOn;
    colour_t pixel;

    // ------------------------------------------------------------------------
    // Sprite coverage
    // ------------------------------------------------------------------------
    assign playerOn = inBox(drawX, drawY, ballX, ballY);
    assign redOn    = inBox(drawX, drawY, ghostRedX, ghostRedY);
    assign greenOn  = inBox(drawX, drawY, ghostGreenX, ghostGreenY);
    assign pinkOn   = inBox(drawX, drawY, ghostPinkX, ghostPinkY);

    // ------------------------------------------------------------------------
    // Fixed priority with player on top and background last
    // ------------------------------------------------------------------------
    always_comb begin
        if (playerOn) begin
            pixel = PlayerColour;
        end else if (wallPixel) begin
            pixel = WallColour;
        end else if (redOn) begin
            pixel = frightened ? FrightColour : GhostRedColour;
        end else if (greenOn) begin
            pixel = frightened ? FrightColour : GhostGreenColour;
        end else if (pinkOn) begin
            pixel = frightened ? FrightColour : GhostPinkColour;
        end else if (pelletPixel) begin
            pixel = PelletColour;
        end else if (powerPixel) begin
            pixel = PowerColour;
        end else begin
            pixel = Background;
        end
    end

    // Split into the three DAC channels
    assign vgaR = pixel[3*ChanWidth-1:2*ChanWidth];
    assign vgaG = pixel[2*ChanWidth-1:ChanWidth];
    assign vgaB = pixel[ChanWidth-1:0];

endmodule

`default_nettype wire

/* hdl/color_mapper.sv */
`timescale 1ns/100ps
`default_nettype none

module color_mapper (
    input  logic                            frame_clk,
    input  logic                            over,
    input  maze_pkg::coord_t                drawX,
    input  maze_pkg::coord_t                drawY,
    input  maze_pkg::coord_t                ballX,
    input  maze_pkg::coord_t                ballY,
    input  maze_pkg::coord_t                ghostRedX,
    input  maze_pkg::coord_t                ghostRedY,
    input  maze_pkg::coord_t                ghostGreenX,
    input  maze_pkg::coord_t                ghostGreenY,
    input  maze_pkg::coord_t                ghostPinkX,
    input  maze_pkg::coord_t                ghostPinkY,
    output logic [maze_pkg::ChanWidth-1:0]  vgaR,
    output logic [maze_pkg::ChanWidth-1:0]  vgaG,
    output logic [maze_pkg::ChanWidth-1:0]  vgaB,
    output logic [maze_pkg::ScoreWidth-1:0] score,
    output logic                            frightened
);

    logic wallPixel;
    logic pelletPixel;
    logic powerPixel;
    logic powerEaten;       // Sticky flag into the timer edge detect

    maze_walls walls (
        .drawX      (drawX),
        .drawY      (drawY),
        .wallPixel  (wallPixel)
    );

    pellet_tracker pellets (
        .frame_clk   (frame_clk),
        .over        (over),
        .ballX       (ballX),
        .ballY       (ballY),
        .drawX       (drawX),
        .drawY       (drawY),
        .pelletPixel (pelletPixel),
        .powerPixel  (powerPixel),
        .score       (score),
        .powerEaten  (powerEaten)
    );

    frightened_timer fright (
        .frame_clk   (frame_clk),
        .over        (over),
        .powerEaten  (powerEaten),
        .frightened  (frightened)
    );

    pixel_colour colour (
        .drawX       (drawX),
        .drawY       (drawY),
        .ballX       (ballX),
        .ballY       (ballY),
        .ghostRedX   (ghostRedX),
        .ghostRedY   (ghostRedY),
        .ghostGreenX (ghostGreenX),
        .ghostGreenY (ghostGreenY),
        .ghostPinkX  (ghostPinkX),
        .ghostPinkY  (ghostPinkY),
        .wallPixel   (wallPixel),
        .pelletPixel (pelletPixel),
        .powerPixel  (powerPixel),
        .frightened  (frightened),
        .vgaR        (vgaR),
        .vgaG        (vgaG),
        .vgaB        (vgaB)
    );

endmodule

`default_nettype wire

/* sim/pixel_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module pixel_checker (
    input  logic                            frame_clk,
    input  logic                            over,
    input  maze_pkg::coord_t                drawX, drawY, ballX, ballY,
    input  maze_pkg::coord_t                ghostRedX, ghostRedY, ghostGreenX, ghostGreenY,
    input  maze_pkg::coord_t                ghostPinkX, ghostPinkY,
    input  logic [maze_pkg::ChanWidth-1:0]  vgaR, vgaG, vgaB,
    input  logic [maze_pkg::ScoreWidth-1:0] score,
    input  logic                            frightened,
    output int                              mismatches
);
    import maze_pkg::*;

    logic [PelletCount-1:0] eatenModel;
    logic                   powerModel;
    logic                   timerFired;     // The power event starts the timer only once
    int                     frightLeft;
    int                     errorCount = 0;
    colour_t                want;

    assign mismatches = errorCount;

    function automatic int sqDistance(coord_t ax, coord_t ay, coord_t bx, coord_t by);
        int dx;
        int dy;
        dx = (ax > bx) ? int'(ax - bx) : int'(bx - ax);
        dy = (ay > by) ? int'(ay - by) : int'(by - ay);
        return dx * dx + dy * dy;
    endfunction

    // Centre minus half excluded and centre plus half included
    function automatic bit covers(coord_t px, coord_t py, coord_t cx, coord_t cy);
        return (px + SpriteHalf > cx) && (px <= cx + SpriteHalf)
            && (py + SpriteHalf > cy) && (py <= cy + SpriteHalf);
    endfunction

    function automatic bit onWall(coord_t x, coord_t y);
        if (x < 8 || y < 8 || x > 631 || y > 471) begin
            return 1'b1;
        end
        for (int i = 0; i < WallCount; i++) begin
            if (x > WallRects[i].xLo && x < WallRects[i].xHi
                && y > WallRects[i].yLo && y < WallRects[i].yHi) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    function automatic bit refFrightened();
        return frightLeft != 0;
    endfunction

    function automatic int refScore();
        int total;
        total = powerModel ? PowerScore : 0;
        for (int i = 0; i < PelletCount; i++) begin
            total += int'(eatenModel[i]);
        end
        return total;
    endfunction

    function automatic colour_t refColour();
        bit pellet;
        bit blue;
        pellet = 1'b0;
        blue = refFrightened();
        for (int i = 0; i < PelletCount; i++) begin
            if (!eatenModel[i]
                && sqDistance(drawX, drawY, PelletX[i], PelletY[i]) <= PelletDrawR2) begin
                pellet = 1'b1;
            end
        end
        if (covers(drawX, drawY, ballX, ballY)) begin
            return PlayerColour;
        end
        if (onWall(drawX, drawY)) begin
            return WallColour;
        end
        if (covers(drawX, drawY, ghostRedX, ghostRedY)) begin
            return blue ? FrightColour : GhostRedColour;
        end
        if (covers(drawX, drawY, ghostGreenX, ghostGreenY)) begin
            return blue ? FrightColour : GhostGreenColour;
        end
        if (covers(drawX, drawY, ghostPinkX, ghostPinkY)) begin
            return blue ? FrightColour : GhostPinkColour;
        end
        if (pellet) begin
            return PelletColour;
        end
        if (!powerModel && sqDistance(drawX, drawY, PowerX, PowerY) <= PowerDrawR2) begin
            return PowerColour;
        end
        return Background;
    endfunction

    // ------------------------------------------------------------------------
    // Game state model updated once per frame
    // ------------------------------------------------------------------------
    always_ff @(posedge frame_clk or posedge over) begin
        if (over) begin
            eatenModel <= '0;
            powerModel <= 1'b0;
            timerFired <= 1'b0;
            frightLeft <= 0;
        end else begin
            for (int i = 0; i < PelletCount; i++) begin
                if (sqDistance(ballX, ballY, PelletX[i], PelletY[i]) <= EatR2) begin
                    eatenModel[i] <= 1'b1;
                end
            end
            if (sqDistance(ballX, ballY, PowerX, PowerY) <= EatR2) begin
                powerModel <= 1'b1;
            end
            if (frightLeft > 0) begin
                frightLeft <= frightLeft - 1;
            end else if (powerModel && !timerFired) begin
                frightLeft <= FrightFrames;     // One frame after the flag is seen
                timerFired <= 1'b1;
            end
        end
    end

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (expected !== actual) begin
            errorCount++;
            $display("FAIL %0t %s expected %0h got %0h", $time, name, expected, actual);
        end
    endtask

    always begin
        @(posedge frame_clk);
        #99;                                    // Just before the next rising edge
        want = refColour();
        compare("vgaR", want[3*ChanWidth-1:2*ChanWidth], vgaR);
        compare("vgaG", want[2*ChanWidth-1:ChanWidth], vgaG);
        compare("vgaB", want[ChanWidth-1:0], vgaB);
        compare("score", refScore(), score);
        compare("frightened", refFrightened(), frightened);
    end

endmodule

`default_nettype wire

/* sim/color_mapper_props.sv */
`timescale 1ns/100ps
`default_nettype none

module color_mapper_props (
    input logic                            frame_clk,
    input logic                            over,
    input logic [maze_pkg::ScoreWidth-1:0] score,
    input logic                            frightened
);
    import maze_pkg::*;

    int highRun;            // Consecutive frames with frightened high
    int failCount = 0;

    always_ff @(posedge frame_clk or posedge over) begin
        if (over) begin
            highRun <= 0;
        end else begin
            highRun <= frightened ? highRun + 1 : 0;
        end
    end

    scoreKeeps: assert property (@(posedge frame_clk) disable iff (over) score >= $past(score))
    else begin
        $error("score decreased while over was low");
        failCount = failCount + 1;
    end

    frightQuietInReset: assert property (@(posedge frame_clk) over |-> !frightened)
    else begin
        $error("frightened high while over is asserted");
        failCount = failCount + 1;
    end

    frightBounded: assert property (@(posedge frame_clk) highRun <= FrightFrames)
    else begin
        $error("frightened stayed high longer than the frightened window");
        failCount = failCount + 1;
    end

endmodule

`default_nettype wire

/* sim/tb_color_mapper.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_color_mapper;
    import maze_pkg::*;

    localparam coord_t ParkX = 11'd320;     // Open floor far from every pellet
    localparam coord_t ParkY = 11'd400;

    logic                  frame_clk = 1'b0;
    logic                  over;
    coord_t                drawX, drawY, ballX, ballY;
    coord_t                ghostRedX, ghostRedY, ghostGreenX, ghostGreenY;
    coord_t                ghostPinkX, ghostPinkY;
    logic [ChanWidth-1:0]  vgaR, vgaG, vgaB;
    logic [ScoreWidth-1:0] score;
    logic                  frightened;
    int                    mismatches;
    int                    timeouts = 0;
    int                    timingErrors = 0;
    int                    n;

    always #50 frame_clk = ~frame_clk;

    color_mapper dut (.*);
    pixel_checker pixelCheck (.*);

    bind color_mapper color_mapper_props props (
        .frame_clk  (frame_clk),
        .over       (over),
        .score      (score),
        .frightened (frightened)
    );

    // Inputs change and outputs are read 1 ns after the rising edge
    task automatic stepCycle();
        @(posedge frame_clk);
        #1;
    endtask

    task automatic aim(input coord_t x, input coord_t y);
        drawX = x;
        drawY = y;
        stepCycle();
    endtask

    task automatic aimGhost(input int k);
        if (k == 0) begin
            aim(ghostRedX, ghostRedY);
        end else if (k == 1) begin
            aim(ghostGreenX, ghostGreenY);
        end else begin
            aim(ghostPinkX, ghostPinkY);
        end
    endtask

    task automatic waitScore(input int want);
        int waited;
        waited = 0;
        while (score != want && waited < 8) begin
            stepCycle();
            waited++;
        end
        if (score != want) begin
            timeouts++;
            $display("Timed out at %0t waiting for score to reach %0d", $time, want);
        end
    endtask

    task automatic placeGhosts();
        ghostRedX = 11'd300;
        ghostRedY = 11'd300;
        ghostGreenX = 11'd400;
        ghostGreenY = 11'd300;
        ghostPinkX = 11'd500;
        ghostPinkY = 11'd300;
    endtask

    task automatic scatterGhosts();
        ghostRedX = coord_t'(16 + $urandom % 600);
        ghostRedY = coord_t'(16 + $urandom % 440);
        ghostGreenX = coord_t'(16 + $urandom % 600);
        ghostGreenY = coord_t'(16 + $urandom % 440);
        ghostPinkX = coord_t'(16 + $urandom % 600);
        ghostPinkY = coord_t'(16 + $urandom % 440);
    endtask

    // Anywhere on screen or close around one of the sprites
    task automatic randomPixels(input int cycles);
        int k;
        coord_t cx;
        coord_t cy;
        for (int i = 0; i < cycles; i++) begin
            k = $urandom % 5;
            cx = (k == 0) ? ghostRedX : (k == 1) ? ghostGreenX : (k == 2) ? ghostPinkX : ballX;
            cy = (k == 0) ? ghostRedY : (k == 1) ? ghostGreenY : (k == 2) ? ghostPinkY : ballY;
            if (k == 4) begin
                aim(coord_t'($urandom % 640), coord_t'($urandom % 480));
            end else begin
                aim(cx + coord_t'($urandom % 12) - 11'd6, cy + coord_t'($urandom % 12) - 11'd6);
            end
        end
    endtask

    initial begin
        void'($urandom(32'hb14c));
        over = 1'b0;
        drawX = '0;
        drawY = '0;
        ballX = ParkX;
        ballY = ParkY;
        placeGhosts();
        #1 over = 1'b1;                     // Rising edge of over clears all state
        repeat (16) @(posedge frame_clk);
        #1;
        over = 1'b0;

        // --------------------------------------------------------------------
        // Random picture then every pellet eaten once and revisited
        // --------------------------------------------------------------------
        repeat (4) begin
            scatterGhosts();
            randomPixels(100);
        end
        placeGhosts();
        for (int i = 0; i < PelletCount; i++) begin
            ballX = PelletX[i];
            ballY = PelletY[i];
            waitScore(i + 1);
            ballX = ParkX;
            ballY = ParkY;
            aim(PelletX[i], PelletY[i]);
            aim(PelletX[i] + 11'd1, PelletY[i]);
        end
        for (int i = 0; i < 2; i++) begin
            ballX = PelletX[i * 5];
            ballY = PelletY[i * 5];
            repeat (3) stepCycle();
        end

        // --------------------------------------------------------------------
        // Power pellet and the frightened window
        // --------------------------------------------------------------------
        ballX = PowerX;
        ballY = PowerY;
        n = 0;
        while (!frightened && n < 8) begin
            stepCycle();
            n++;
        end
        ballX = ParkX;
        ballY = ParkY;
        if (!frightened) begin
            timeouts++;
            $display("Timed out at %0t waiting for frightened mode to start", $time);
        end else if (n != 2) begin
            timingErrors++;
            $display("FAIL %0t frightened rise delay expected %0d got %0d", $time, 2, n);
        end
        n = 1;
        while (frightened && n <= FrightFrames + 4) begin
            aimGhost(n % 3);
            if (frightened) n++;
        end
        if (frightened) begin
            timeouts++;
            $display("Timed out at %0t waiting for frightened mode to end", $time);
        end else if (n != FrightFrames) begin
            timingErrors++;
            $display("FAIL %0t frightened high cycles expected %0d got %0d",
                     $time, FrightFrames, n);
        end
        for (int k = 0; k < 3; k++) begin
            aimGhost(k);
        end

        // Player over the red ghost then red over pink
        ballX = ghostRedX;
        ballY = ghostRedY;
        aim(ghostRedX, ghostRedY);
        ballX = ParkX;
        ballY = ParkY;
        ghostRedX = ghostPinkX;
        ghostRedY = ghostPinkY;
        for (int d = 0; d < 8; d++) begin
            aim(ghostPinkX - 11'd3 + coord_t'(d), ghostPinkY + coord_t'(d % 3));
        end
        placeGhosts();

        // Game over then power pellet again and game over inside the window
        over = 1'b1;
        stepCycle();
        over = 1'b0;
        ballX = PowerX;
        ballY = PowerY;
        waitScore(PowerScore);
        ballX = ParkX;
        ballY = ParkY;
        repeat (5) stepCycle();
        over = 1'b1;
        repeat (2) stepCycle();
        over = 1'b0;
        for (int i = 0; i < PelletCount; i++) begin
            aim(PelletX[i], PelletY[i]);
        end
        aim(PowerX, PowerY);
        stepCycle();

        $display("Errors: %0d pixel checker, %0d timing, %0d timeouts, %0d assertions",
                 mismatches, timingErrors, timeouts, dut.props.failCount);
        if (mismatches + timingErrors + timeouts + dut.props.failCount == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
hdl/maze_pkg.sv
hdl/maze_walls.sv
hdl/pellet_tracker.sv
hdl/frightened_timer.sv
hdl/pixel_colour.sv
hdl/color_mapper.sv
sim/pixel_checker.sv
sim/color_mapper_props.sv
sim/tb_color_mapper.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_color_mapper -f filelist.f

./obj_dir/Vtb_color_mapper +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation PASSED" sim.log; then
    exit 0
fi
exit 1
